//--- hdl/ctr_cmd_decode.sv
/*
  Command checker, purely combinational with zero latency.
  Commands are single-cycle strobes and nothing is queued. A legal command
  while the FSM is busy is a protocol fault, not a retry.
*/

`timescale 1ns/1ps

module ctr_cmd_decode import ctr_pkg::*; (
  // Command strobe from outside
  input  logic     cmd_valid_i,
  input  ctr_cmd_e cmd_op_i,
  // FSM idle level
  input  logic     ready_i,

  // Accepted requests
  output logic     load_o,
  output logic     incr_o,

  // Fault pulses to the FSM
  output logic     incr_err_o,
  output logic     mr_err_o
);

  //////////////////////////////////////////////////////////////////////
  // Opcode check
  //////////////////////////////////////////////////////////////////////

  logic op_legal;
  logic is_load;
  logic is_incr;

  // Anything outside the two sparse codes is an encoding fault
  assign op_legal = cmd_op_i inside {CMD_LOAD, CMD_INCR};

  // Exact compares, no partial decoding of the sparse code
  assign is_load = (cmd_op_i == CMD_LOAD);
  assign is_incr = (cmd_op_i == CMD_INCR);

  //////////////////////////////////////////////////////////////////////
  // Fault flags
  //////////////////////////////////////////////////////////////////////

  // Bad encoding takes precedence over the busy check
  assign mr_err_o   = cmd_valid_i & ~op_legal;

  // Legal opcode, but an increment is still walking the slices
  assign incr_err_o = cmd_valid_i & op_legal & ~ready_i;

  //////////////////////////////////////////////////////////////////////
  // Request strobes
  //////////////////////////////////////////////////////////////////////

  logic accept;

  // Only a clean command in idle gets through
  assign accept = cmd_valid_i & op_legal & ready_i;

  assign load_o = accept & is_load;
  assign incr_o = accept & is_incr;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // One strobe per command, the sparse codes never both match
  a_load_incr_onehot: assert final (!(load_o && incr_o))
    else $error("load_o and incr_o high together");

endmodule : ctr_cmd_decode

//--- hdl/ctr_fsm.sv
/*
  Slice-wise increment FSM, one SliceWidth slice per clock, LSB slice first.
  An increment takes CtrWidth/SliceWidth cycles with ready_o low.
  CTR_ERROR is terminal. Only rst_ni leaves it and alert_o stays high there.
*/

`timescale 1ns/1ps

module ctr_fsm import ctr_pkg::*; #(
  parameter int unsigned SliceWidth = 16
) (
  input  logic clk_i,
  input  logic rst_ni,

  // Control
  input  logic incr_i,
  output logic ready_o,
  input  logic incr_err_i,
  input  logic mr_err_i,
  output logic alert_o,

  // Slice access to the counter storage
  output logic [$clog2(CtrWidth/SliceWidth)-1:0] ctr_slice_idx_o,
  input  logic [SliceWidth-1:0]                  ctr_slice_i,
  output logic [SliceWidth-1:0]                  ctr_slice_o,
  output logic                                   ctr_we_o
);

  localparam int unsigned NumSlices     = CtrWidth / SliceWidth;
  localparam int unsigned SliceIdxWidth = $clog2(NumSlices);

  ctr_state_e               state_d, state_q;
  logic [SliceIdxWidth-1:0] slice_idx_d, slice_idx_q;
  logic                     carry_d, carry_q;
  logic [SliceWidth:0]      slice_sum;

  //////////////////////////////////////////////////////////////////////
  // Slice adder
  //////////////////////////////////////////////////////////////////////

  // One extra bit catches the carry-out into the next slice
  assign slice_sum   = {1'b0, ctr_slice_i} + {{SliceWidth{1'b0}}, carry_q};
  assign ctr_slice_o = slice_sum[SliceWidth-1:0];

  //////////////////////////////////////////////////////////////////////
  // Next state logic
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Defaults
    ready_o     = 1'b0;
    ctr_we_o    = 1'b0;
    alert_o     = 1'b0;
    state_d     = state_q;
    slice_idx_d = slice_idx_q;
    carry_d     = carry_q;

    unique case (state_q)
      CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at the bottom slice with a carry of one
          slice_idx_d = '0;
          carry_d     = 1'b1;
          state_d     = CTR_INCR;
        end
      end

      CTR_INCR: begin
        // Write back this slice, hand the carry up
        ctr_we_o    = 1'b1;
        slice_idx_d = slice_idx_q + SliceIdxWidth'(1);
        carry_d     = slice_sum[SliceWidth];
        // Top slice written, back to idle
        if (slice_idx_q == SliceIdxWidth'(NumSlices - 1)) begin
          state_d = CTR_IDLE;
        end
      end

      CTR_ERROR: begin
        // Terminal, no way out but reset
        alert_o = 1'b1;
      end

      default: begin
        // Corrupted state code, fail safe
        alert_o = 1'b1;
        state_d = CTR_ERROR;
      end
    endcase

    // Faults from the decoder win over every transition
    if (incr_err_i || mr_err_i) begin
      state_d = CTR_ERROR;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= CTR_IDLE;
      slice_idx_q <= '0;
      carry_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      slice_idx_q <= slice_idx_d;
      carry_q     <= carry_d;
    end
  end

  assign ctr_slice_idx_o = slice_idx_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // No alert means a legal working state
  a_state_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !alert_o |-> state_q inside {CTR_IDLE, CTR_INCR})
    else $error("state %s without alert", state_q.name());

  // Slice writes only while incrementing
  a_we_in_incr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctr_we_o |-> state_q == CTR_INCR)
    else $error("slice write in state %s", state_q.name());

endmodule : ctr_fsm

//--- hdl/ctr_pkg.sv
/*
  Shared constants and enums for the CTR-mode counter path.
  Only CMD_LOAD and CMD_INCR are legal opcodes. Every other 3-bit code is
  an encoding fault. FSM state codes outside the enum are illegal too.
*/

package ctr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Counter geometry
  //////////////////////////////////////////////////////////////////////

  // Full counter width, one AES block
  parameter int unsigned CtrWidth = 128;

  //////////////////////////////////////////////////////////////////////
  // Command opcodes
  //////////////////////////////////////////////////////////////////////

  // Sparse codes, two bits apart from each other
  // A single flipped bit never turns one legal opcode into the other
  typedef enum logic [2:0] {
    CMD_LOAD = 3'b011,
    CMD_INCR = 3'b101
  } ctr_cmd_e;

  //////////////////////////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////////////////////////

  // Plain one-hot codes, the remaining five codes count as illegal
  typedef enum logic [2:0] {
    CTR_IDLE  = 3'b001,
    CTR_INCR  = 3'b010,
    CTR_ERROR = 3'b100
  } ctr_state_e;

endpackage : ctr_pkg

//--- hdl/ctr_state_reg.sv
/*
  128-bit counter storage split into CtrWidth/SliceWidth slices.
  SliceWidth must be 8, 16 or 32. A full load and a slice write in the same
  cycle is not supported, and load wins if it happens anyway.
*/

`timescale 1ns/1ps

module ctr_state_reg import ctr_pkg::*; #(
  parameter int unsigned SliceWidth = 16
) (
  input  logic clk_i,
  input  logic rst_ni,

  // Full load from outside
  input  logic                load_i,
  input  logic [CtrWidth-1:0] load_data_i,

  // Slice port, driven by the FSM
  input  logic [$clog2(CtrWidth/SliceWidth)-1:0] slice_idx_i,
  input  logic                                   slice_we_i,
  input  logic [SliceWidth-1:0]                  slice_data_i,
  output logic [SliceWidth-1:0]                  slice_o,

  // Whole counter
  output logic [CtrWidth-1:0] ctr_o
);

  localparam int unsigned NumSlices = CtrWidth / SliceWidth;

  //////////////////////////////////////////////////////////////////////
  // Parameter check
  //////////////////////////////////////////////////////////////////////

  // Only these widths divide the counter into a power-of-two slice count
  if (!(SliceWidth inside {8, 16, 32})) begin : gen_bad_width
    $error("SliceWidth %0d unsupported, use 8, 16 or 32", SliceWidth);
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // Packed array puts slice 0 at the LSBs of the flat counter
  logic [NumSlices-1:0][SliceWidth-1:0] ctr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q <= '0;
    end else if (load_i) begin
      // Whole block at once
      ctr_q <= load_data_i;
    end else if (slice_we_i) begin
      // Just the slice the FSM is working on
      ctr_q[slice_idx_i] <= slice_data_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  // Combinational slice mux back to the FSM adder
  assign slice_o = ctr_q[slice_idx_i];

  assign ctr_o = ctr_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Loads come only in idle and slice writes only mid-increment
  a_load_we_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_i && slice_we_i))
    else $error("load and slice write in the same cycle");

endmodule : ctr_state_reg

//--- hdl/ctr_top.sv
/*
  CTR-mode counter path. Commands are one-cycle strobes, no handshake.
  A command while ready_o is low, or a bad opcode, locks the block in its
  error state with alert_o high until reset.
*/

`timescale 1ns/1ps

module ctr_top import ctr_pkg::*; #(
  parameter int unsigned SliceWidth = 16
) (
  input  logic clk_i,
  input  logic rst_ni,

  // Command side
  input  logic                cmd_valid_i,
  input  ctr_cmd_e            cmd_op_i,
  input  logic [CtrWidth-1:0] load_data_i,

  // Status and counter value
  output logic [CtrWidth-1:0] ctr_o,
  output logic                ready_o,
  output logic                alert_o
);

  localparam int unsigned SliceIdxWidth = $clog2(CtrWidth / SliceWidth);

  //////////////////////////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////////////////////////

  // Decoder to FSM and storage
  logic load;
  logic incr;
  logic incr_err;
  logic mr_err;

  // FSM to storage slice port
  logic [SliceIdxWidth-1:0] slice_idx;
  logic [SliceWidth-1:0]    slice_rd;
  logic [SliceWidth-1:0]    slice_wr;
  logic                     slice_we;

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  ctr_cmd_decode u_cmd_decode (
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .ready_i     (ready_o),
    .load_o      (load),
    .incr_o      (incr),
    .incr_err_o  (incr_err),
    .mr_err_o    (mr_err)
  );

  ctr_fsm #(
    .SliceWidth (SliceWidth)
  ) u_ctr_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .incr_i          (incr),
    .ready_o         (ready_o),
    .incr_err_i      (incr_err),
    .mr_err_i        (mr_err),
    .alert_o         (alert_o),
    .ctr_slice_idx_o (slice_idx),
    .ctr_slice_i     (slice_rd),
    .ctr_slice_o     (slice_wr),
    .ctr_we_o        (slice_we)
  );

  ctr_state_reg #(
    .SliceWidth (SliceWidth)
  ) u_state_reg (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_i       (load),
    .load_data_i  (load_data_i),
    .slice_idx_i  (slice_idx),
    .slice_we_i   (slice_we),
    .slice_data_i (slice_wr),
    .slice_o      (slice_rd),
    .ctr_o        (ctr_o)
  );

endmodule : ctr_top

//--- sources.f
hdl/ctr_pkg.sv
hdl/ctr_cmd_decode.sv
hdl/ctr_fsm.sv
hdl/ctr_state_reg.sv
hdl/ctr_top.sv
verif/ctr_model.sv
verif/ctr_tb.sv

//--- verif/ctr_model.sv
/*
  Cycle-level reference for the counter path, fed with the same raw strobes
  as the DUT. The counter value jumps to +1 at the accepting edge. Compare
  exp_ctr_o with the DUT only while exp_ready_o is high.
*/

`timescale 1ns/1ps

module ctr_model import ctr_pkg::*; #(
  parameter int unsigned SliceWidth = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Same command strobes as the DUT sees
  input  logic                cmd_valid_i,
  input  logic [2:0]          cmd_op_i,
  input  logic [CtrWidth-1:0] load_data_i,

  // Expected outputs
  output logic [CtrWidth-1:0] exp_ctr_o,
  output logic                exp_ready_o,
  output logic                exp_alert_o
);

  localparam int unsigned NumSlices = CtrWidth / SliceWidth;

  logic [CtrWidth-1:0] ctr_q;
  int unsigned         busy_q;
  logic                alert_q;
  logic                op_legal;

  // Only the two sparse codes are legal
  assign op_legal = (cmd_op_i == CMD_LOAD) || (cmd_op_i == CMD_INCR);

  // Idle means no increment in flight and no fault seen
  assign exp_ready_o = !alert_q && (busy_q == 0);
  assign exp_alert_o = alert_q;
  assign exp_ctr_o   = ctr_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q   <= '0;
      busy_q  <= 0;
      alert_q <= 1'b0;
    end else begin
      // One slice per cycle, so NumSlices busy cycles
      if (busy_q != 0) begin
        busy_q <= busy_q - 1;
      end
      if (cmd_valid_i) begin
        if (!op_legal || !exp_ready_o) begin
          // Bad opcode or command while busy, sticky
          alert_q <= 1'b1;
        end else if (cmd_op_i == CMD_LOAD) begin
          ctr_q <= load_data_i;
        end else begin
          // Wraps modulo 2^128 by width
          ctr_q  <= ctr_q + 1'b1;
          busy_q <= NumSlices;
        end
      end
    end
  end

endmodule : ctr_model

//--- verif/ctr_tb.sv
/*
  Testbench for ctr_top with the default 16-bit slices.
  Stimulus is seeded random, driven on the rising edge, sampled on the
  falling edge. Stops at the first mismatch or timeout.
*/

`timescale 1ns/1ps

module ctr_tb import ctr_pkg::*; ();

  localparam int unsigned SliceWidth = 16;
  localparam int unsigned NumSlices  = CtrWidth / SliceWidth;

  logic                clk;
  logic                rst_n;
  logic                cmd_valid;
  ctr_cmd_e            cmd_op;
  logic [CtrWidth-1:0] load_data;
  logic [CtrWidth-1:0] ctr;
  logic                ready;
  logic                alert;
  logic [CtrWidth-1:0] exp_ctr;
  logic                exp_ready;
  logic                exp_alert;
  integer              seed;

  ctr_top #(
    .SliceWidth (SliceWidth)
  ) i_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_op_i    (cmd_op),
    .load_data_i (load_data),
    .ctr_o       (ctr),
    .ready_o     (ready),
    .alert_o     (alert)
  );

  ctr_model #(
    .SliceWidth (SliceWidth)
  ) i_model (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_op_i    (cmd_op),
    .load_data_i (load_data),
    .exp_ctr_o   (exp_ctr),
    .exp_ready_o (exp_ready),
    .exp_alert_o (exp_alert)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic flag_mismatch(input string name, input logic [CtrWidth-1:0] exp,
                               input logic [CtrWidth-1:0] act);
    $display("[FAIL] %s expected %h actual %h", name, exp, act);
    abort_run();
  endtask

  task automatic check_val(input string name, input logic [CtrWidth-1:0] exp,
                           input logic [CtrWidth-1:0] act);
    assert (act === exp) else flag_mismatch(name, exp, act);
  endtask

  // Status levels follow the model every cycle out of reset
  always @(negedge clk) begin
    if (rst_n) begin
      assert (ready === exp_ready) else flag_mismatch("ready_monitor", exp_ready, ready);
      assert (alert === exp_alert) else flag_mismatch("alert_monitor", exp_alert, alert);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [CtrWidth-1:0] rand128();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst_n     <= 1'b0;
    cmd_valid <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // One-cycle strobe, returns just after the edge that samples it
  task automatic send_cmd(input ctr_cmd_e op, input logic [CtrWidth-1:0] data);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    load_data <= data;
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  // Counts falling edges with ready_o low, bounded at 20
  task automatic wait_ready(input string name, output int low_cycles);
    low_cycles = 0;
    @(negedge clk);
    while (!ready) begin
      low_cycles++;
      if (low_cycles > 20) begin
        $display("Timeout in %s: ready_o stayed low for more than 20 cycles", name);
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  // Load a start value, increment it, check busy length and result
  task automatic run_incr(input string name, input logic [CtrWidth-1:0] start);
    int low_cycles;
    send_cmd(CMD_LOAD, start);
    @(negedge clk);
    check_val({name, "_load"}, exp_ctr, ctr);
    send_cmd(CMD_INCR, rand128());
    wait_ready(name, low_cycles);
    check_val({name, "_busy_cycles"}, NumSlices, low_cycles);
    check_val(name, exp_ctr, ctr);
  endtask

  // Checks the locked error state after a faulty command
  task automatic check_locked(input string name);
    @(negedge clk);
    check_val({name, "_alert"}, 1'b1, alert);
    check_val({name, "_ready"}, 1'b0, ready);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [CtrWidth-1:0] data;
    logic [2:0]          bits;
    seed      = 32'h88e6_dae0;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = CMD_LOAD;
    load_data = '0;
    apply_reset();

    // Reset values
    @(negedge clk);
    check_val("reset_ctr", '0, ctr);
    check_val("reset_ready", 1'b1, ready);
    check_val("reset_alert", 1'b0, alert);

    // Random loads
    repeat (8) begin
      data = rand128();
      send_cmd(CMD_LOAD, data);
      @(negedge clk);
      check_val("load_random", data, ctr);
      check_val("load_model", exp_ctr, ctr);
    end

    // Plain random increments
    repeat (6) begin
      run_incr("incr_random", rand128());
    end

    // Low k slices all ones, carry ripples k slices up
    for (int k = 1; k < NumSlices; k++) begin
      data = rand128() | ((128'd1 << (k * SliceWidth)) - 1'b1);
      run_incr("incr_ripple", data);
    end

    // All ones wraps to zero
    run_incr("incr_wrap", '1);
    check_val("incr_wrap_zero", '0, ctr);

    // Any command during an increment is a protocol fault
    send_cmd(CMD_LOAD, rand128());
    send_cmd(CMD_INCR, rand128());
    bits = $random(seed);
    send_cmd(bits[0] ? CMD_LOAD : CMD_INCR, rand128());
    check_locked("busy_cmd");
    repeat (6) begin
      bits = $random(seed);
      send_cmd(ctr_cmd_e'(bits), rand128());
      check_locked("busy_cmd_sticky");
    end

    // Fresh reset, then a bad opcode
    apply_reset();
    @(negedge clk);
    check_val("rereset_ctr", '0, ctr);
    check_val("rereset_ready", 1'b1, ready);
    check_val("rereset_alert", 1'b0, alert);
    bits = $random(seed);
    while (bits == CMD_LOAD || bits == CMD_INCR) begin
      bits = $random(seed);
    end
    send_cmd(ctr_cmd_e'(bits), rand128());
    check_locked("bad_opcode");
    repeat (4) begin
      send_cmd(CMD_LOAD, rand128());
      check_locked("bad_opcode_sticky");
    end

    $display("TEST PASS");
    $finish;
  end

endmodule : ctr_tb
